// File: hdl/apbPkg.sv
package apbPkg;

    typedef logic [11:0] apbAddrT;
    typedef logic [31:0] apbDataT;

    // Register map of the multiplier peripheral
    localparam apbAddrT RegOp1    = 12'h000; // First operand
    localparam apbAddrT RegOp2    = 12'h004; // Second operand
    localparam apbAddrT RegCtrl   = 12'h008; // Write only
    localparam apbAddrT RegStatus = 12'h00C; // Read only
    localparam apbAddrT RegResLo  = 12'h010; // Product bits 31 to 0
    localparam apbAddrT RegResHi  = 12'h014; // Product bits 63 to 32

    localparam int CtrlStartBit  = 0;
    localparam int StatusBusyBit = 0;
    localparam int StatusDoneBit = 1;

endpackage

// File: hdl/mulPkg.sv
package mulPkg;

    localparam int OpWidth = 32;

    typedef logic [OpWidth-1:0]   operandT;
    typedef logic [2*OpWidth-1:0] productT; // Also the width of every tree row

    // Tree level whose output rows are registered
    localparam int DefaultSplitLevel = 4;

endpackage

// File: hdl/mulIf.sv
interface mulIf;
    import mulPkg::*;

    logic    opValid;
    operandT op1;
    operandT op2;
    logic    resValid;
    productT res;

    modport host (
        output opValid,
        output op1,
        output op2,
        input  resValid,
        input  res
    );

    modport core (
        input  opValid,
        input  op1,
        input  op2,
        output resValid,
        output res
    );

endinterface

// File: hdl/ppGen.sv
module ppGen (
    input  mulPkg::operandT op1,
    input  mulPkg::operandT op2,
    output mulPkg::productT pp [mulPkg::OpWidth]
);
    import mulPkg::*;

    productT op1Ext;

    assign op1Ext = productT'(op1); // Zero extension to the product width

    for (genvar i = 0; i < OpWidth; i++) begin : gRow
        assign pp[i] = op2[i] ? (op1Ext << i) : '0;
    end

endmodule

// File: hdl/csaTree.sv
module csaTree #(
    parameter int SplitLevel = mulPkg::DefaultSplitLevel
) (
    input  logic            clk,
    input  mulPkg::productT pp [mulPkg::OpWidth],
    output mulPkg::productT sumRow,
    output mulPkg::productT carryRow
);
    import mulPkg::*;

    localparam int NumPp     = OpWidth;
    localparam int TreeDepth = 8;

    // Rows left after a given number of 3:2 levels
    function automatic int rowCount(input int level);
        int n;
        n = NumPp;
        for (int i = 0; i < level; i++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    localparam int PipeRows = rowCount(SplitLevel);

    productT stage [TreeDepth+1][NumPp];     // Rows produced by each level
    productT levelIn [1:TreeDepth][NumPp];   // Rows entering each level
    productT pipeRows [PipeRows];

    if (SplitLevel < 1 || SplitLevel > TreeDepth) begin : gBadSplit
        $error("csaTree SplitLevel %0d is outside 1 to %0d", SplitLevel, TreeDepth);
    end

    for (genvar r = 0; r < NumPp; r++) begin : gLevel0
        assign stage[0][r] = pp[r];
    end

    for (genvar l = 1; l <= TreeDepth; l++) begin : gLevel
        localparam int NIn  = rowCount(l - 1);
        localparam int NGrp = NIn / 3;

        for (genvar r = 0; r < NIn; r++) begin : gSrc
            if (l - 1 == SplitLevel) begin : gFromReg
                assign levelIn[l][r] = pipeRows[r];
            end else begin : gFromComb
                assign levelIn[l][r] = stage[l-1][r];
            end
        end

        for (genvar g = 0; g < NGrp; g++) begin : gCsa
            productT x;
            productT y;
            productT z;

            assign x = levelIn[l][3*g];
            assign y = levelIn[l][3*g+1];
            assign z = levelIn[l][3*g+2];
            assign stage[l][2*g]   = x ^ y ^ z;
            assign stage[l][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1; // Carry weighs one bit up
        end

        // Rows that do not fill a group move on untouched
        for (genvar r = 3 * NGrp; r < NIn; r++) begin : gPass
            assign stage[l][2*NGrp+r-3*NGrp] = levelIn[l][r];
        end
    end

    for (genvar r = 0; r < PipeRows; r++) begin : gPipe
        always_ff @(posedge clk) begin
            pipeRows[r] <= stage[SplitLevel][r];
        end
    end

    if (SplitLevel == TreeDepth) begin : gOutReg
        assign sumRow   = pipeRows[0];
        assign carryRow = pipeRows[1];
    end else begin : gOutComb
        assign sumRow   = stage[TreeDepth][0];
        assign carryRow = stage[TreeDepth][1];
    end

endmodule

// File: hdl/finalAdder.sv
module finalAdder (
    input  mulPkg::productT a,
    input  mulPkg::productT b,
    output mulPkg::productT sum
);
    import mulPkg::*;

    localparam int Groups = $bits(productT) / 4;

    productT            g;
    productT            p;
    logic [Groups-1:0]  c; // Carry into each 4-bit group

    assign g    = a & b;
    assign p    = a ^ b;
    assign c[0] = 1'b0;

    for (genvar grp = 0; grp < Groups; grp++) begin : gGroup
        logic [3:0] gb;
        logic [3:0] pb;
        logic [3:0] cb;

        assign gb    = g[4*grp +: 4];
        assign pb    = p[4*grp +: 4];
        assign cb[0] = c[grp];
        assign cb[1] = gb[0] | (pb[0] & c[grp]);
        assign cb[2] = gb[1] | (pb[1] & gb[0]) | (pb[1] & pb[0] & c[grp]);
        assign cb[3] = gb[2] | (pb[2] & gb[1]) | (pb[2] & pb[1] & gb[0])
                     | (pb[2] & pb[1] & pb[0] & c[grp]);
        assign sum[4*grp +: 4] = pb ^ cb;

        if (grp < Groups - 1) begin : gNext
            logic grpG;
            logic grpP;

            assign grpG = gb[3] | (pb[3] & gb[2]) | (pb[3] & pb[2] & gb[1])
                        | (pb[3] & pb[2] & pb[1] & gb[0]);
            assign grpP = &pb;
            assign c[grp+1] = grpG | (grpP & c[grp]);
        end
    end

endmodule

// File: hdl/wallaceMul.sv
module wallaceMul #(
    parameter int SplitLevel = mulPkg::DefaultSplitLevel
) (
    input logic clk,
    input logic rstN,
    mulIf.core  mul
);
    import mulPkg::*;

    productT pp [OpWidth];
    productT sumRow;
    productT carryRow;
    productT sum;
    logic    validMid; // Valid flag beside the tree register

    ppGen ppGen_inst (
        .op1 (mul.op1),
        .op2 (mul.op2),
        .pp  (pp)
    );

    csaTree #(
        .SplitLevel (SplitLevel)
    ) csaTree_inst (
        .clk      (clk),
        .pp       (pp),
        .sumRow   (sumRow),
        .carryRow (carryRow)
    );

    finalAdder finalAdder_inst (
        .a   (sumRow),
        .b   (carryRow),
        .sum (sum)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validMid     <= 1'b0;
            mul.resValid <= 1'b0;
        end else begin
            validMid     <= mul.opValid;
            mul.resValid <= validMid;
        end
    end

    always_ff @(posedge clk) begin
        mul.res <= sum;
    end

    // Two cycle latency whatever the split level
    assert property (@(posedge clk) disable iff (!rstN)
        mul.resValid == $past(mul.opValid, 2));

endmodule

// File: hdl/apbMulRegs.sv
module apbMulRegs (
    input  logic            clk,
    input  logic            rstN,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apbPkg::apbAddrT paddr,
    input  apbPkg::apbDataT pwdata,
    output apbPkg::apbDataT prdata,
    output logic            pready,
    output logic            pslverr,
    mulIf.host              mul
);
    import apbPkg::*;
    import mulPkg::*;

    typedef enum logic {
        idle,
        access
    } apbStateT;

    apbStateT state;
    operandT  op1Reg;
    operandT  op2Reg;
    productT  resultReg;
    logic     busy;
    logic     done;
    logic     accessPhase;
    logic     isOpReg;
    logic     isCtrl;
    logic     isStatus;
    logic     isRes;
    logic     stall;
    logic     err;
    logic     wrOk;
    logic     startReq;

    assign isOpReg  = (paddr == RegOp1) || (paddr == RegOp2);
    assign isCtrl   = paddr == RegCtrl;
    assign isStatus = paddr == RegStatus;
    assign isRes    = (paddr == RegResLo) || (paddr == RegResHi);

    assign accessPhase = (state == access) && psel && penable;
    assign stall       = !pwrite && isRes && busy; // Result reads wait for the product

    always_comb begin
        err = 1'b0;
        if (!(isOpReg || isCtrl || isStatus || isRes)) begin
            err = 1'b1;
        end else if (pwrite && (isStatus || isRes)) begin
            err = 1'b1;
        end else if (!pwrite && isCtrl) begin
            err = 1'b1;
        end else if (pwrite && busy) begin
            err = 1'b1; // Operands and control are locked while the core works
        end
    end

    assign pready   = accessPhase && !stall;
    assign pslverr  = pready && err;
    assign wrOk     = pready && pwrite && !err;
    assign startReq = wrOk && isCtrl && pwdata[CtrlStartBit];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (psel) state <= access;
                access:  if (pready || !psel) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            op1Reg <= '0;
            op2Reg <= '0;
        end else if (wrOk) begin
            if (paddr == RegOp1) op1Reg <= pwdata;
            if (paddr == RegOp2) op2Reg <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mul.opValid <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
            resultReg   <= '0;
        end else begin
            mul.opValid <= startReq; // One cycle pulse per start
            if (startReq) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (mul.resValid) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (mul.resValid) resultReg <= mul.res;
        end
    end

    assign mul.op1 = op1Reg;
    assign mul.op2 = op2Reg;

    always_comb begin
        prdata = '0;
        case (paddr)
            RegOp1:    prdata = op1Reg;
            RegOp2:    prdata = op2Reg;
            RegStatus: begin
                prdata[StatusBusyBit] = busy;
                prdata[StatusDoneBit] = done;
            end
            RegResLo:  prdata = resultReg[31:0];
            RegResHi:  prdata = resultReg[63:32];
            default:   prdata = '0;
        endcase
    end

    // Only one operation may be in flight from this block
    assert property (@(posedge clk) disable iff (!rstN) mul.opValid |-> !$past(busy));
    assert property (@(posedge clk) disable iff (!rstN) mul.resValid |-> busy);

endmodule

// File: hdl/mulApbTop.sv
module mulApbTop #(
    parameter int SplitLevel = mulPkg::DefaultSplitLevel
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apbPkg::apbAddrT paddr,
    input  apbPkg::apbDataT pwdata,
    output apbPkg::apbDataT prdata,
    output logic            pready,
    output logic            pslverr
);

    mulIf mulBus ();

    apbMulRegs apbMulRegs_inst (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mul     (mulBus.host)
    );

    wallaceMul #(
        .SplitLevel (SplitLevel)
    ) wallaceMul_inst (
        .clk  (clk),
        .rstN (rstN),
        .mul  (mulBus.core)
    );

endmodule

// File: dv/mulApbTb.sv
module mulApbTb;
    timeunit 1ns;
    timeprecision 100ps;

    import apbPkg::*;
    import mulPkg::*;

    localparam int QuarterPeriod    = 25;
    localparam int NumRandom        = 200;
    localparam int CyclesPerProduct = 16; // Five transfers of two cycles plus status polls
    localparam int MaxCycles        = 2 * CyclesPerProduct * (NumRandom + 50);

    logic    clk;
    logic    rstN;
    logic    psel;
    logic    penable;
    logic    pwrite;
    apbAddrT paddr;
    apbDataT pwdata;
    apbDataT prdata;
    logic    pready;
    logic    pslverr;
    int      cycleCount = 0;
    int      lastWaits; // Wait states seen by the latest transfer

    mulApbTop mulApbTop_inst (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("Run did not finish within %0d cycles", MaxCycles);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkProduct(input string name, input productT expected,
                                input productT actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkData(input string name, input apbDataT expected,
                             input apbDataT actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkErr(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected pslverr %b, actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    function automatic productT refProduct(input operandT a, input operandT b);
        return productT'(a) * productT'(b);
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer ends
    task automatic apbTransfer(input logic write, input apbAddrT addr, input apbDataT wdata,
                               output apbDataT rdata, output logic err);
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = write;
        paddr     = addr;
        pwdata    = wdata;
        @(negedge clk);
        penable   = 1'b1;
        lastWaits = 0;
        #QuarterPeriod; // Sample well before the rising edge
        while (pready !== 1'b1) begin
            @(negedge clk);
            #QuarterPeriod;
            lastWaits++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbWrite(input apbAddrT addr, input apbDataT data, output logic err);
        apbDataT unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input apbAddrT addr, output apbDataT data, output logic err);
        apbTransfer(1'b0, addr, '0, data, err);
    endtask

    task automatic writeOk(input string name, input apbAddrT addr, input apbDataT data);
        logic err;
        apbWrite(addr, data, err);
        checkErr(name, 1'b0, err);
    endtask

    task automatic readOk(input string name, input apbAddrT addr, output apbDataT data);
        logic err;
        apbRead(addr, data, err);
        checkErr(name, 1'b0, err);
    endtask

    task automatic readCheck(input string name, input apbAddrT addr, input apbDataT expected);
        apbDataT data;
        readOk(name, addr, data);
        checkData(name, expected, data);
    endtask

    task automatic waitDone(input string name);
        apbDataT status;
        readOk(name, RegStatus, status);
        while (!status[StatusDoneBit]) begin
            readOk(name, RegStatus, status);
        end
    endtask

    task automatic readProduct(input string name, output productT value);
        apbDataT lo;
        apbDataT hi;
        readOk(name, RegResLo, lo);
        readOk(name, RegResHi, hi);
        value = {hi, lo};
    endtask

    task automatic runProduct(input string name, input operandT a, input operandT b);
        productT actual;
        writeOk(name, RegOp1, a);
        writeOk(name, RegOp2, b);
        writeOk(name, RegCtrl, 32'h1);
        waitDone(name);
        readProduct(name, actual);
        checkProduct(name, refProduct(a, b), actual);
    endtask

    task automatic testReset();
        readCheck("reset status", RegStatus, 32'h0);
        readCheck("reset op1", RegOp1, 32'h0);
        readCheck("reset op2", RegOp2, 32'h0);
        readCheck("reset result low", RegResLo, 32'h0);
        readCheck("reset result high", RegResHi, 32'h0);
    endtask

    task automatic testDirected();
        operandT x;
        x = $urandom();
        runProduct("zero times x", 32'h0, x);
        runProduct("x times zero", x, 32'h0);
        runProduct("one times x", 32'h1, x);
        runProduct("all ones squared", 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        runProduct("msb times two", 32'h8000_0000, 32'h2);
        for (int i = 0; i < OpWidth; i += 3) begin
            runProduct($sformatf("single bits %0d", i), operandT'(1) << i,
                       operandT'(1) << ((7 * i) % OpWidth));
        end
    endtask

    task automatic testRandom();
        operandT a;
        operandT b;
        for (int n = 0; n < NumRandom; n++) begin
            a = $urandom();
            b = $urandom();
            runProduct($sformatf("random %0d", n), a, b);
        end
    endtask

    task automatic testStalledRead();
        operandT a;
        operandT b;
        apbDataT hi;
        apbDataT lo;
        a = $urandom();
        b = $urandom();
        writeOk("stalled read", RegOp1, a);
        writeOk("stalled read", RegOp2, b);
        writeOk("stalled read", RegCtrl, 32'h1);
        readOk("stalled read", RegResHi, hi);
        if (lastWaits == 0) begin
            $display("Result read right after a start completed without wait states");
            abortRun();
        end
        readOk("stalled read", RegResLo, lo);
        checkProduct("stalled read", refProduct(a, b), {hi, lo});
        readCheck("stalled read status", RegStatus, 32'h2); // Done set, busy clear
    endtask

    task automatic testErrors();
        logic    err;
        apbDataT data;
        operandT a;
        operandT b;
        productT product;
        productT expected;
        apbRead(12'h018, data, err);
        checkErr("unmapped read", 1'b1, err);
        apbRead(RegCtrl, data, err);
        checkErr("control read", 1'b1, err);
        a = $urandom();
        b = $urandom();
        expected = refProduct(a, b);
        writeOk("op1 write while busy", RegOp1, a);
        writeOk("op1 write while busy", RegOp2, b);
        writeOk("op1 write while busy", RegCtrl, 32'h1);
        apbWrite(RegOp1, ~a, err); // Lands in the cycle right after the start
        checkErr("op1 write while busy", 1'b1, err);
        waitDone("op1 write while busy");
        readProduct("op1 write while busy", product);
        checkProduct("op1 write while busy", expected, product);
        readCheck("op1 after refused write", RegOp1, a);
        writeOk("second start", RegCtrl, 32'h1);
        apbWrite(RegCtrl, 32'h1, err);
        checkErr("second start", 1'b1, err);
        waitDone("second start");
        readProduct("second start", product);
        checkProduct("second start", expected, product);
        readCheck("status after second start", RegStatus, 32'h2);
        apbWrite(RegStatus, 32'hFFFF_FFFF, err);
        checkErr("status write", 1'b1, err);
        readCheck("status after write", RegStatus, 32'h2); // Still done and idle
        apbWrite(RegResLo, ~expected[31:0], err);
        checkErr("result write", 1'b1, err);
        readCheck("result after write", RegResLo, expected[31:0]);
    endtask

    initial begin
        clk     = 1'b0;
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'h8ea3a10a));
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        testReset();
        testDirected();
        testRandom();
        testStalledRead();
        testErrors();
        $display("Test passed");
        $finish;
    end

endmodule

// File: list.f
hdl/apbPkg.sv
hdl/mulPkg.sv
hdl/mulIf.sv
hdl/ppGen.sv
hdl/csaTree.sv
hdl/finalAdder.sv
hdl/wallaceMul.sv
hdl/apbMulRegs.sv
hdl/mulApbTop.sv
dv/mulApbTb.sv

// File: Bender.yml
package:
  name: mul_apb

sources:
  - files:
      - hdl/apbPkg.sv
      - hdl/mulPkg.sv
      - hdl/mulIf.sv
      - hdl/ppGen.sv
      - hdl/csaTree.sv
      - hdl/finalAdder.sv
      - hdl/wallaceMul.sv
      - hdl/apbMulRegs.sv
      - hdl/mulApbTop.sv
  - target: test
    files:
      - dv/mulApbTb.sv
